/* verilog.f */
istream_pkg.sv
istream_marker_scan.sv
istream_queue.sv
istream_way_select.sv
istream.sv
istream_checker.sv
tb_istream.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --assert -Wno-fatal
TOP      = tb_istream
FILELIST = verilog.f
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench, fail if the log reports failure"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if grep -q "Test FAILED" $(LOG); then exit 1; fi; \
	exit $$status

clean:
	rm -rf obj_dir $(LOG)

/* tb_istream.sv */
`timescale 1ns/100ps

module tb_istream;

    localparam int SETS = 8;
    localparam istream_pkg::pc_t INIT_PC = 32'h0000_1000;
    localparam int TIMEOUT = 200;
    localparam int N = istream_pkg::CHUNKS_PER_SET;
    localparam int WAYS = istream_pkg::WAYS;

    logic CLK;
    logic nRST;
    logic valid_senq;
    logic [N-1:0] valid_by_chunk_senq;
    istream_pkg::chunk_t [N-1:0] instr_by_chunk_senq;
    istream_pkg::pc_t after_pc_senq;
    logic stall_sdeq;
    logic restart;
    istream_pkg::pc_t restart_pc;
    logic stall_senq;
    logic valid_sdeq;
    logic [WAYS-1:0] valid_by_way_sdeq;
    logic [WAYS-1:0] uncompressed_by_way_sdeq;
    istream_pkg::chunk_t [WAYS-1:0][1:0] instr_by_way_by_chunk_sdeq;
    istream_pkg::pc_t [WAYS-1:0] pc_by_way_sdeq;

    // ------------------------------------------------------------
    // reference model: expected instructions in program order
    istream_pkg::pc_t exp_pc[$];
    istream_pkg::chunk_t exp_lo[$];
    istream_pkg::chunk_t exp_hi[$];
    logic exp_unc[$];
    istream_pkg::pc_t set_start;
    logic carry;
    istream_pkg::pc_t carry_pc;
    istream_pkg::chunk_t carry_lo;

    int errors;
    int test_errors;
    int tests;
    int failed_tests;
    int unc_pct;
    int accepted;
    int n;
    int seed;
    logic force_lead;

    istream #(
        .ISTREAM_SETS(SETS),
        .INIT_PC(INIT_PC)
    ) DUT (
        .CLK(CLK),
        .nRST(nRST),
        .valid_senq(valid_senq),
        .valid_by_chunk_senq(valid_by_chunk_senq),
        .instr_by_chunk_senq(instr_by_chunk_senq),
        .after_pc_senq(after_pc_senq),
        .stall_senq(stall_senq),
        .valid_sdeq(valid_sdeq),
        .valid_by_way_sdeq(valid_by_way_sdeq),
        .uncompressed_by_way_sdeq(uncompressed_by_way_sdeq),
        .instr_by_way_by_chunk_sdeq(instr_by_way_by_chunk_sdeq),
        .pc_by_way_sdeq(pc_by_way_sdeq),
        .stall_sdeq(stall_sdeq),
        .restart(restart),
        .restart_pc(restart_pc)
    );

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    // chunk index lands in pc bits 3..1
    function automatic istream_pkg::pc_t chunk_pc(istream_pkg::pc_t start, int i);
        return (start & ~32'hE) | istream_pkg::pc_t'(i << 1);
    endfunction

    task automatic push_exp(istream_pkg::pc_t pc, istream_pkg::chunk_t lo,
                            istream_pkg::chunk_t hi, logic unc);
        exp_pc.push_back(pc);
        exp_lo.push_back(lo);
        exp_hi.push_back(hi);
        exp_unc.push_back(unc);
    endtask

    task automatic model_accept();
        for (int i = 0; i < N; i++) begin
            if (valid_by_chunk_senq[i]) begin
                if (carry) begin
                    push_exp(carry_pc, carry_lo, instr_by_chunk_senq[i], 1'b1);
                    carry = 1'b0;
                end else if (instr_by_chunk_senq[i][1:0] == 2'b11) begin
                    carry = 1'b1;
                    carry_pc = chunk_pc(set_start, i);
                    carry_lo = instr_by_chunk_senq[i];
                end else begin
                    push_exp(chunk_pc(set_start, i), instr_by_chunk_senq[i], '0, 1'b0);
                end
            end
        end
        set_start = after_pc_senq;
    endtask

    task automatic model_clear(istream_pkg::pc_t pc);
        exp_pc.delete();
        exp_lo.delete();
        exp_hi.delete();
        exp_unc.delete();
        carry = 1'b0;
        set_start = pc;
    endtask

    // random set, never without a valid chunk
    task automatic gen_set();
        valid_by_chunk_senq = N'($urandom);
        if (valid_by_chunk_senq == '0 || force_lead) begin
            valid_by_chunk_senq[0] = 1'b1;
        end
        for (int i = 0; i < N; i++) begin
            instr_by_chunk_senq[i] = 16'($urandom);
            if (int'($urandom % 100) < unc_pct) begin
                instr_by_chunk_senq[i][1:0] = 2'b11;
            end else begin
                instr_by_chunk_senq[i][0] = 1'b0;
            end
        end
        after_pc_senq = $urandom & 32'hFFFF_FFF0;
    endtask

    task automatic check_ways();
        for (int w = 0; w < WAYS; w++) begin
            if (valid_by_way_sdeq[w]) begin
                if (exp_pc.size() == 0) begin
                    $display("way %0d offered an instruction that was never sent", w);
                    errors++;
                end else begin
                    assert (pc_by_way_sdeq[w] == exp_pc[0]) else begin
                        $display("ERROR pc_by_way_sdeq[%0d] got %h expected %h",
                                 w, pc_by_way_sdeq[w], exp_pc[0]);
                        errors++;
                    end
                    assert (instr_by_way_by_chunk_sdeq[w][0] == exp_lo[0]) else begin
                        $display("ERROR instr_by_way_by_chunk_sdeq[%0d][0] got %h expected %h",
                                 w, instr_by_way_by_chunk_sdeq[w][0], exp_lo[0]);
                        errors++;
                    end
                    assert (uncompressed_by_way_sdeq[w] == exp_unc[0]) else begin
                        $display("ERROR uncompressed_by_way_sdeq[%0d] got %h expected %h",
                                 w, uncompressed_by_way_sdeq[w], exp_unc[0]);
                        errors++;
                    end
                    if (exp_unc[0]) begin
                        assert (instr_by_way_by_chunk_sdeq[w][1] == exp_hi[0]) else begin
                            $display("ERROR instr_by_way_by_chunk_sdeq[%0d][1] got %h expected %h",
                                     w, instr_by_way_by_chunk_sdeq[w][1], exp_hi[0]);
                            errors++;
                        end
                    end
                    void'(exp_pc.pop_front());
                    void'(exp_lo.pop_front());
                    void'(exp_hi.pop_front());
                    void'(exp_unc.pop_front());
                end
            end
        end
    endtask

    // one cycle: drive at the falling edge, sample once settled
    task automatic step(logic enq, logic hold);
        @(negedge CLK);
        valid_senq = enq;
        stall_sdeq = hold;
        gen_set();
        #1;
        if (!hold) begin
            check_ways();
        end
        if (enq && !stall_senq) begin
            model_accept();
            accepted++;
        end
    endtask

    task automatic drain(int hold_pct);
        n = 0;
        while (exp_pc.size() != 0 && n < TIMEOUT) begin
            step(1'b0, int'($urandom % 100) < hold_pct);
            n++;
        end
        if (exp_pc.size() != 0) begin
            $display("drain timed out with %0d instructions still expected", exp_pc.size());
            errors++;
        end
    endtask

    // enqueue during the restart cycle must be dropped
    task automatic pulse_restart(istream_pkg::pc_t pc);
        @(negedge CLK);
        restart = 1'b1;
        restart_pc = pc;
        valid_senq = 1'b1;
        stall_sdeq = 1'b0;
        gen_set();
        @(negedge CLK);
        restart = 1'b0;
        valid_senq = 1'b0;
        model_clear(pc);
        #1;
        assert (!valid_sdeq) else begin
            $display("ERROR valid_sdeq got %h expected 0", valid_sdeq);
            errors++;
        end
    endtask

    task automatic end_test(string name);
        tests++;
        if (errors != test_errors) begin
            failed_tests++;
        end
        $display("test %0d %s: %0d errors", tests, name, errors - test_errors);
        test_errors = errors;
    endtask

    initial begin
        seed = $urandom(18);
        nRST = 1'b0;
        valid_senq = 1'b0;
        valid_by_chunk_senq = '0;
        instr_by_chunk_senq = '0;
        after_pc_senq = '0;
        stall_sdeq = 1'b1;
        restart = 1'b0;
        restart_pc = '0;
        errors = 0;
        test_errors = 0;
        tests = 0;
        failed_tests = 0;
        unc_pct = 0;
        accepted = 0;
        force_lead = 1'b0;
        model_clear(INIT_PC);
        repeat (16) @(negedge CLK);
        nRST = 1'b1;
        #1;

        // ------------------------------------------------------------
        // 1: idle after reset, first pc
        assert (!valid_sdeq && !stall_senq) else begin
            $display("ERROR valid_sdeq %h stall_senq %h expected 0", valid_sdeq, stall_senq);
            errors++;
        end
        force_lead = 1'b1;
        step(1'b1, 1'b1);
        force_lead = 1'b0;
        n = 0;
        while (!valid_sdeq && n < TIMEOUT) begin
            step(1'b0, 1'b1);
            n++;
        end
        if (!valid_sdeq) begin
            $display("valid_sdeq never rose after the first set");
            errors++;
        end else begin
            assert (pc_by_way_sdeq[0] == INIT_PC) else begin
                $display("ERROR pc_by_way_sdeq[0] got %h expected %h", pc_by_way_sdeq[0], INIT_PC);
                errors++;
            end
        end
        drain(0);
        end_test("reset and first pc");

        // 2: compressed only
        repeat (40) step(1'b1, ($urandom % 4) == 0);
        drain(0);
        end_test("compressed stream");

        // 3: mixed, uncompressed may straddle sets
        unc_pct = 40;
        repeat (60) step(1'b1, ($urandom % 4) == 0);
        drain(0);
        end_test("mixed stream");

        // 4: fill with dequeue held
        pulse_restart(32'h0000_4000);
        unc_pct = 25;
        accepted = 0;
        n = 0;
        while (!stall_senq && n < TIMEOUT) begin
            step(1'b1, 1'b1);
            n++;
        end
        repeat (4) step(1'b1, 1'b1);
        if (!stall_senq || accepted != SETS) begin
            $display("queue took %0d sets before stalling, expected %0d", accepted, SETS);
            errors++;
        end
        end_test("fill and stall");

        // 5: drain with random back-pressure
        drain(30);
        end_test("drain with back-pressure");

        // 6: restart to a new pc
        repeat (3) step(1'b1, 1'b1);
        pulse_restart(32'h0008_0000);
        repeat (20) step(1'b1, ($urandom % 3) == 0);
        drain(0);
        end_test("restart");

        if (DUT.u_checker.fail_count != 0) begin
            $display("bound checker saw %0d failed assertions", DUT.u_checker.fail_count);
            errors += DUT.u_checker.fail_count;
        end
        $display("tests %0d, failed %0d, errors %0d", tests, failed_tests, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* istream_checker.sv */
`timescale 1ns/100ps

module istream_checker (
    input  logic CLK,
    input  logic nRST,
    input  logic restart,
    input  logic stall_sdeq,
    input  logic valid_sdeq,
    input  logic [istream_pkg::WAYS-1:0] valid_by_way_sdeq,
    input  logic [istream_pkg::WAYS-1:0] uncompressed_by_way_sdeq,
    input  istream_pkg::chunk_t [istream_pkg::WAYS-1:0][1:0] instr_by_way_by_chunk_sdeq,
    input  istream_pkg::pc_t [istream_pkg::WAYS-1:0] pc_by_way_sdeq
);

    // failed assertions so far
    int fail_count = 0;

    a_valid_way0: assert property (@(posedge CLK) disable iff (!nRST)
        valid_sdeq |-> valid_by_way_sdeq[0])
        else begin
            $error("valid_sdeq high with way 0 invalid");
            fail_count++;
        end

    a_restart_idle: assert property (@(posedge CLK) disable iff (!nRST)
        restart |=> !valid_sdeq && (valid_by_way_sdeq == '0))
        else begin
            $error("output valid in the cycle after restart");
            fail_count++;
        end

    // ------------------------------------------------------------
    // per way

    for (genvar w = 0; w < istream_pkg::WAYS; w++) begin : g_way
        if (w > 0) begin : g_contig
            a_contig: assert property (@(posedge CLK) disable iff (!nRST)
                valid_by_way_sdeq[w] |-> valid_by_way_sdeq[w-1])
                else begin
                    $error("way %0d valid after an invalid way", w);
                    fail_count++;
                end
        end

        // an offered way holds while dequeue is stalled
        a_hold: assert property (@(posedge CLK) disable iff (!nRST)
            stall_sdeq && !restart && valid_by_way_sdeq[w] |=>
                valid_by_way_sdeq[w] && $stable(pc_by_way_sdeq[w])
                && $stable(instr_by_way_by_chunk_sdeq[w])
                && $stable(uncompressed_by_way_sdeq[w]))
            else begin
                $error("way %0d changed while stall_sdeq was high", w);
                fail_count++;
            end
    end

endmodule

bind istream istream_checker u_checker (
    .CLK(CLK),
    .nRST(nRST),
    .restart(restart),
    .stall_sdeq(stall_sdeq),
    .valid_sdeq(valid_sdeq),
    .valid_by_way_sdeq(valid_by_way_sdeq),
    .uncompressed_by_way_sdeq(uncompressed_by_way_sdeq),
    .instr_by_way_by_chunk_sdeq(instr_by_way_by_chunk_sdeq),
    .pc_by_way_sdeq(pc_by_way_sdeq)
);

/* istream.sv */
`timescale 1ns/100ps

module istream #(
    parameter int ISTREAM_SETS = 8,
    parameter istream_pkg::pc_t INIT_PC = '0
) (
    input  logic CLK,
    input  logic nRST,

    // enqueue side
    input  logic valid_senq,
    input  logic [istream_pkg::CHUNKS_PER_SET-1:0] valid_by_chunk_senq,
    input  istream_pkg::chunk_t [istream_pkg::CHUNKS_PER_SET-1:0] instr_by_chunk_senq,
    input  istream_pkg::pc_t after_pc_senq,
    output logic stall_senq,

    // dequeue side
    output logic valid_sdeq,
    output logic [istream_pkg::WAYS-1:0] valid_by_way_sdeq,
    output logic [istream_pkg::WAYS-1:0] uncompressed_by_way_sdeq,
    output istream_pkg::chunk_t [istream_pkg::WAYS-1:0][1:0] instr_by_way_by_chunk_sdeq,
    output istream_pkg::pc_t [istream_pkg::WAYS-1:0] pc_by_way_sdeq,
    input  logic stall_sdeq,

    input  logic restart,
    input  istream_pkg::pc_t restart_pc
);

    logic enq_fire;
    logic [istream_pkg::CHUNKS_PER_SET-1:0] enq_uncompressed_vec;
    logic [istream_pkg::CHUNKS_PER_SET-1:0] enq_marker_vec;
    logic [istream_pkg::WIN_CHUNKS-1:0] valid_vec;
    logic [istream_pkg::WIN_CHUNKS-1:0] uncompressed_vec;
    logic [istream_pkg::WIN_CHUNKS-1:0] marker_vec;
    logic [istream_pkg::WIN_CHUNKS-1:0] ack_vec;
    logic [1:0] set_valid;
    istream_pkg::chunk_t [istream_pkg::WIN_CHUNKS-1:0] instr_vec;
    istream_pkg::pc_t base_pc0;
    istream_pkg::pc_t after_pc0;
    istream_pkg::deq_action_e deq_action;

    istream_marker_scan u_scan (
        .CLK(CLK),
        .nRST(nRST),
        .restart(restart),
        .enq_fire(enq_fire),
        .valid_by_chunk(valid_by_chunk_senq),
        .instr_by_chunk(instr_by_chunk_senq),
        .enq_uncompressed_vec(enq_uncompressed_vec),
        .enq_marker_vec(enq_marker_vec)
    );

    istream_queue #(
        .ISTREAM_SETS(ISTREAM_SETS),
        .INIT_PC(INIT_PC)
    ) u_queue (
        .CLK(CLK),
        .nRST(nRST),
        .restart(restart),
        .restart_pc(restart_pc),
        .valid_senq(valid_senq),
        .valid_by_chunk(valid_by_chunk_senq),
        .instr_by_chunk(instr_by_chunk_senq),
        .after_pc(after_pc_senq),
        .enq_uncompressed_vec(enq_uncompressed_vec),
        .enq_marker_vec(enq_marker_vec),
        .ack_vec(ack_vec),
        .deq_action(deq_action),
        .stall_sdeq(stall_sdeq),
        .stall_senq(stall_senq),
        .enq_fire(enq_fire),
        .valid_vec(valid_vec),
        .uncompressed_vec(uncompressed_vec),
        .marker_vec(marker_vec),
        .set_valid(set_valid),
        .instr_vec(instr_vec),
        .base_pc0(base_pc0),
        .after_pc0(after_pc0)
    );

    istream_way_select u_way_select (
        .valid_vec(valid_vec),
        .uncompressed_vec(uncompressed_vec),
        .marker_vec(marker_vec),
        .set_valid(set_valid),
        .instr_vec(instr_vec),
        .base_pc0(base_pc0),
        .after_pc0(after_pc0),
        .stall_sdeq(stall_sdeq),
        .valid_sdeq(valid_sdeq),
        .valid_by_way_sdeq(valid_by_way_sdeq),
        .uncompressed_by_way_sdeq(uncompressed_by_way_sdeq),
        .instr_by_way_by_chunk_sdeq(instr_by_way_by_chunk_sdeq),
        .pc_by_way_sdeq(pc_by_way_sdeq),
        .ack_vec(ack_vec),
        .deq_action(deq_action)
    );

endmodule

/* istream_way_select.sv */
`timescale 1ns/100ps

module istream_way_select (
    input  logic [istream_pkg::WIN_CHUNKS-1:0] valid_vec,
    input  logic [istream_pkg::WIN_CHUNKS-1:0] uncompressed_vec,
    input  logic [istream_pkg::WIN_CHUNKS-1:0] marker_vec,
    input  logic [1:0] set_valid,
    input  istream_pkg::chunk_t [istream_pkg::WIN_CHUNKS-1:0] instr_vec,
    input  istream_pkg::pc_t base_pc0,
    input  istream_pkg::pc_t after_pc0,
    input  logic stall_sdeq,
    output logic valid_sdeq,
    output logic [istream_pkg::WAYS-1:0] valid_by_way_sdeq,
    output logic [istream_pkg::WAYS-1:0] uncompressed_by_way_sdeq,
    output istream_pkg::chunk_t [istream_pkg::WAYS-1:0][1:0] instr_by_way_by_chunk_sdeq,
    output istream_pkg::pc_t [istream_pkg::WAYS-1:0] pc_by_way_sdeq,
    output logic [istream_pkg::WIN_CHUNKS-1:0] ack_vec,
    output istream_pkg::deq_action_e deq_action
);

    localparam int W = istream_pkg::WIN_CHUNKS;
    localparam int N = istream_pkg::CHUNKS_PER_SET;

    logic [W-1:0] remain_vec;
    logic done0;
    logic done1;

    function automatic logic [W-1:0] lowest_one(input logic [W-1:0] req);
        return req & (~req + 1'b1);
    endfunction

    function automatic logic [istream_pkg::WIN_IDX_W-1:0] one_hot_index(
        input logic [W-1:0] oh
    );
        logic [istream_pkg::WIN_IDX_W-1:0] idx;
        idx = '0;
        for (int i = 0; i < W; i++) begin
            if (oh[i]) begin
                idx = idx | istream_pkg::WIN_IDX_W'(i);
            end
        end
        return idx;
    endfunction

    // ------------------------------------------------------------
    // per-way lower/upper chunk pick

    always_comb begin : way_pick
        logic [W-1:0] lower_req;
        logic [W-1:0] lower_oh;
        logic [W-1:0] upper_oh;
        logic [istream_pkg::WIN_IDX_W-1:0] lower_idx;
        logic alive;
        logic unc;
        logic ok;
        istream_pkg::pc_t set_pc;

        lower_req = marker_vec;
        alive = set_valid[0];
        ack_vec = '0;
        for (int w = 0; w < istream_pkg::WAYS; w++) begin
            lower_oh = lowest_one(lower_req);
            lower_idx = one_hot_index(lower_oh);
            // next valid chunk strictly above the lower one
            upper_oh = lowest_one(valid_vec & ~(lower_oh | (lower_oh - 1'b1)));
            unc = |(uncompressed_vec & lower_oh);
            ok = alive && (|lower_oh) && (!unc || (|upper_oh));

            valid_by_way_sdeq[w] = ok;
            uncompressed_by_way_sdeq[w] = ok && unc;
            instr_by_way_by_chunk_sdeq[w] = '0;
            for (int i = 0; i < W; i++) begin
                if (lower_oh[i]) begin
                    instr_by_way_by_chunk_sdeq[w][0] = instr_vec[i];
                end
                if (unc && upper_oh[i]) begin
                    instr_by_way_by_chunk_sdeq[w][1] = instr_vec[i];
                end
            end

            // lower chunk in set 1 takes its pc from set 0's after_pc
            set_pc = lower_idx[istream_pkg::WIN_IDX_W-1] ? after_pc0 : base_pc0;
            pc_by_way_sdeq[w] = {set_pc[istream_pkg::PC_W-1:4], lower_idx[2:0], set_pc[0]};

            if (ok) begin
                ack_vec = ack_vec | lower_oh | (unc ? upper_oh : '0);
            end
            alive = ok;
            lower_req = lower_req & ~lower_oh;
        end
    end

    assign valid_sdeq = set_valid[0] && valid_by_way_sdeq[0];

    // ------------------------------------------------------------
    // retirement

    assign remain_vec = valid_vec & ~ack_vec;
    assign done0 = set_valid[0] && !(|remain_vec[N-1:0]);
    assign done1 = done0 && set_valid[1] && !(|remain_vec[W-1:N]);

    always_comb begin
        if (stall_sdeq) begin
            deq_action = istream_pkg::DEQ_NONE;
        end else if (done1) begin
            deq_action = istream_pkg::DEQ_TWO;
        end else if (done0) begin
            deq_action = istream_pkg::DEQ_ONE;
        end else begin
            deq_action = istream_pkg::DEQ_NONE;
        end
    end

endmodule

/* istream_queue.sv */
`timescale 1ns/100ps

module istream_queue #(
    parameter int ISTREAM_SETS = 8,
    parameter istream_pkg::pc_t INIT_PC = '0
) (
    input  logic CLK,
    input  logic nRST,
    input  logic restart,
    input  istream_pkg::pc_t restart_pc,
    input  logic valid_senq,
    input  logic [istream_pkg::CHUNKS_PER_SET-1:0] valid_by_chunk,
    input  istream_pkg::chunk_t [istream_pkg::CHUNKS_PER_SET-1:0] instr_by_chunk,
    input  istream_pkg::pc_t after_pc,
    input  logic [istream_pkg::CHUNKS_PER_SET-1:0] enq_uncompressed_vec,
    input  logic [istream_pkg::CHUNKS_PER_SET-1:0] enq_marker_vec,
    input  logic [istream_pkg::WIN_CHUNKS-1:0] ack_vec,
    input  istream_pkg::deq_action_e deq_action,
    input  logic stall_sdeq,
    output logic stall_senq,
    output logic enq_fire,
    output logic [istream_pkg::WIN_CHUNKS-1:0] valid_vec,
    output logic [istream_pkg::WIN_CHUNKS-1:0] uncompressed_vec,
    output logic [istream_pkg::WIN_CHUNKS-1:0] marker_vec,
    output logic [1:0] set_valid,
    output istream_pkg::chunk_t [istream_pkg::WIN_CHUNKS-1:0] instr_vec,
    output istream_pkg::pc_t base_pc0,
    output istream_pkg::pc_t after_pc0
);

    localparam int N = istream_pkg::CHUNKS_PER_SET;
    localparam int IDX_W = $clog2(ISTREAM_SETS);

    // ------------------------------------------------------------
    // ring storage

    istream_pkg::chunk_t [N-1:0] chunk_mem [ISTREAM_SETS];
    istream_pkg::pc_t after_pc_mem [ISTREAM_SETS];

    logic [IDX_W:0] enq_ptr;
    logic [IDX_W:0] deq0_ptr;
    logic [IDX_W:0] occ;
    logic [IDX_W-1:0] deq1_idx;
    istream_pkg::pc_t set_pc;

    // compacted status, slot 0 is the oldest set
    logic [ISTREAM_SETS-1:0][N-1:0] valid_arr, valid_mid, valid_nx;
    logic [ISTREAM_SETS-1:0][N-1:0] unc_arr, unc_mid, unc_nx;
    logic [ISTREAM_SETS-1:0][N-1:0] mark_arr, mark_mid, mark_nx;
    logic [ISTREAM_SETS-1:0] set_valid_arr, set_mid, set_nx;
    logic [1:0] shamt;

    assign stall_senq = (enq_ptr[IDX_W-1:0] == deq0_ptr[IDX_W-1:0])
        && (enq_ptr[IDX_W] != deq0_ptr[IDX_W]);
    assign enq_fire = valid_senq && !stall_senq;
    assign occ = enq_ptr - deq0_ptr;
    assign deq1_idx = IDX_W'(deq0_ptr[IDX_W-1:0] + 1'b1);

    assign valid_vec = {valid_arr[1], valid_arr[0]};
    assign uncompressed_vec = {unc_arr[1], unc_arr[0]};
    assign marker_vec = {mark_arr[1], mark_arr[0]};
    assign set_valid = set_valid_arr[1:0];
    assign instr_vec[N-1:0] = chunk_mem[deq0_ptr[IDX_W-1:0]];
    assign instr_vec[2*N-1:N] = chunk_mem[deq1_idx];
    assign base_pc0 = set_pc;
    assign after_pc0 = after_pc_mem[deq0_ptr[IDX_W-1:0]];

    always_comb begin
        case (deq_action)
            istream_pkg::DEQ_ONE: shamt = 2'd1;
            istream_pkg::DEQ_TWO: shamt = 2'd2;
            default:              shamt = 2'd0;
        endcase
    end

    always_comb begin : status_next
        valid_mid = valid_arr;
        unc_mid = unc_arr;
        mark_mid = mark_arr;
        set_mid = set_valid_arr;
        // consumed chunks drop out
        if (!stall_sdeq) begin
            valid_mid[0] = valid_arr[0] & ~ack_vec[N-1:0];
            valid_mid[1] = valid_arr[1] & ~ack_vec[2*N-1:N];
            mark_mid[0] = mark_arr[0] & ~ack_vec[N-1:0];
            mark_mid[1] = mark_arr[1] & ~ack_vec[2*N-1:N];
        end
        // new set lands in the first empty slot
        if (enq_fire) begin
            valid_mid[occ[IDX_W-1:0]] = valid_by_chunk;
            unc_mid[occ[IDX_W-1:0]] = enq_uncompressed_vec;
            mark_mid[occ[IDX_W-1:0]] = enq_marker_vec;
            set_mid[occ[IDX_W-1:0]] = 1'b1;
        end
        for (int i = 0; i < ISTREAM_SETS; i++) begin
            if (i + shamt < ISTREAM_SETS) begin
                valid_nx[i] = valid_mid[i + shamt];
                unc_nx[i] = unc_mid[i + shamt];
                mark_nx[i] = mark_mid[i + shamt];
                set_nx[i] = set_mid[i + shamt];
            end else begin
                valid_nx[i] = '0;
                unc_nx[i] = '0;
                mark_nx[i] = '0;
                set_nx[i] = 1'b0;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (enq_fire) begin
            chunk_mem[enq_ptr[IDX_W-1:0]] <= instr_by_chunk;
            after_pc_mem[enq_ptr[IDX_W-1:0]] <= after_pc;
        end
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            enq_ptr <= '0;
            deq0_ptr <= '0;
            set_pc <= INIT_PC;
            valid_arr <= '0;
            unc_arr <= '0;
            mark_arr <= '0;
            set_valid_arr <= '0;
        end else if (restart) begin
            enq_ptr <= '0;
            deq0_ptr <= '0;
            set_pc <= restart_pc;
            valid_arr <= '0;
            unc_arr <= '0;
            mark_arr <= '0;
            set_valid_arr <= '0;
        end else begin
            if (enq_fire) begin
                enq_ptr <= enq_ptr + 1'b1;
            end
            deq0_ptr <= deq0_ptr + (IDX_W+1)'(shamt);
            // set pc follows the last retired set
            if (deq_action == istream_pkg::DEQ_ONE) begin
                set_pc <= after_pc_mem[deq0_ptr[IDX_W-1:0]];
            end else if (deq_action == istream_pkg::DEQ_TWO) begin
                set_pc <= after_pc_mem[deq1_idx];
            end
            valid_arr <= valid_nx;
            unc_arr <= unc_nx;
            mark_arr <= mark_nx;
            set_valid_arr <= set_nx;
        end
    end

endmodule

/* istream_marker_scan.sv */
`timescale 1ns/100ps

module istream_marker_scan (
    input  logic CLK,
    input  logic nRST,
    input  logic restart,
    input  logic enq_fire,
    input  logic [istream_pkg::CHUNKS_PER_SET-1:0] valid_by_chunk,
    input  istream_pkg::chunk_t [istream_pkg::CHUNKS_PER_SET-1:0] instr_by_chunk,
    output logic [istream_pkg::CHUNKS_PER_SET-1:0] enq_uncompressed_vec,
    output logic [istream_pkg::CHUNKS_PER_SET-1:0] enq_marker_vec
);

    localparam int N = istream_pkg::CHUNKS_PER_SET;

    // pending[i] means an uncompressed start still needs its second chunk
    logic [N:0] pending;
    logic carry_q;

    always_comb begin
        pending[0] = carry_q;
        for (int i = 0; i < N; i++) begin
            enq_uncompressed_vec[i] = (instr_by_chunk[i][1:0] == 2'b11);
            if (!valid_by_chunk[i]) begin
                enq_marker_vec[i] = 1'b0;
                pending[i+1] = pending[i];
            end else if (pending[i]) begin
                // second half of the previous instruction
                enq_marker_vec[i] = 1'b0;
                pending[i+1] = 1'b0;
            end else begin
                enq_marker_vec[i] = 1'b1;
                pending[i+1] = enq_uncompressed_vec[i];
            end
        end
    end

    // carry into the next accepted set
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            carry_q <= 1'b0;
        end else if (restart) begin
            carry_q <= 1'b0;
        end else if (enq_fire) begin
            carry_q <= pending[N];
        end
    end

endmodule

/* istream_pkg.sv */
package istream_pkg;

    // ------------------------------------------------------------
    // set geometry

    // two-byte chunks per fetch set
    localparam int CHUNKS_PER_SET = 8;

    // dequeue window spans the two oldest sets
    localparam int WIN_CHUNKS = 2 * CHUNKS_PER_SET;
    localparam int WIN_IDX_W = $clog2(WIN_CHUNKS);

    // instructions offered per cycle
    localparam int WAYS = 4;

    localparam int CHUNK_W = 16;
    localparam int PC_W = 32;

    // ------------------------------------------------------------
    // types

    typedef logic [CHUNK_W-1:0] chunk_t;

    // byte address
    typedef logic [PC_W-1:0] pc_t;

    // retirement command from way select to queue
    typedef enum logic [1:0] {
        DEQ_NONE = 2'd0,
        DEQ_ONE  = 2'd1,
        DEQ_TWO  = 2'd2
    } deq_action_e;

endpackage
